// ==== include/ahb_mtx_defines.svh ====
// Widths and AHB encodings shared by every output stage RTL file and its testbench through include
`ifndef AHB_MTX_DEFINES_SVH
`define AHB_MTX_DEFINES_SVH

// ------------------------------
// Port count and bus widths
// ------------------------------
`define AHB_NUM_PORTS      3        // Competing input ports
`define AHB_PORT_W         2        // Enough bits for a port number
`define AHB_ADDR_W         32       // HADDR
`define AHB_DATA_W         32       // HWDATA
`define AHB_MASTER_W       4        // HMASTER
`define AHB_PROT_W         4        // HPROT
`define AHB_BEAT_W         4        // Up to 15 remaining beats

// ------------------------------
// HTRANS codes
// ------------------------------
`define AHB_TRANS_IDLE     2'b00
`define AHB_TRANS_BUSY     2'b01
`define AHB_TRANS_NONSEQ   2'b10
`define AHB_TRANS_SEQ      2'b11

// ------------------------------
// HBURST codes
// ------------------------------
`define AHB_BURST_SINGLE   3'b000
`define AHB_BURST_INCR     3'b001   // Undefined length
`define AHB_BURST_WRAP4    3'b010
`define AHB_BURST_INCR4    3'b011
`define AHB_BURST_WRAP8    3'b100
`define AHB_BURST_INCR8    3'b101
`define AHB_BURST_WRAP16   3'b110
`define AHB_BURST_INCR16   3'b111

`endif

// ==== rtl/ahb_mtx_pkg.sv ====
// Types for the output stage blocks, referenced with ahb_mtx_pkg:: scoped names
`default_nettype none

`include "ahb_mtx_defines.svh"

package ahb_mtx_pkg;

  // ------------------------------
  // Plain vectors
  // ------------------------------
  typedef logic [`AHB_ADDR_W-1:0]   addr_t;     // HADDR
  typedef logic [`AHB_DATA_W-1:0]   data_t;     // HWDATA
  typedef logic [1:0]               trans_t;    // HTRANS
  typedef logic [2:0]               burst_t;    // HBURST
  typedef logic [2:0]               size_t;     // HSIZE
  typedef logic [`AHB_PROT_W-1:0]   prot_t;     // HPROT
  typedef logic [`AHB_MASTER_W-1:0] master_t;   // HMASTER
  typedef logic [`AHB_PORT_W-1:0]   port_idx_t; // Input port number
  typedef logic [`AHB_BEAT_W-1:0]   beat_t;     // Beats left in a fixed burst

  // ------------------------------
  // Address phase bundle
  // ------------------------------
  // One port's address and control, same layout on the slave side
  typedef struct packed
  {
    logic    sel;       // HSEL
    addr_t   addr;      // HADDR
    trans_t  trans;     // HTRANS
    logic    write;     // HWRITE
    size_t   size;      // HSIZE
    burst_t  burst;     // HBURST
    prot_t   prot;      // HPROT
    master_t master;    // HMASTER
    logic    mastlock;  // HMASTLOCK
  } ahb_ctrl_t;

  // Registered arbitration result
  typedef struct packed
  {
    logic      no_port; // Nobody owns the slave
    port_idx_t port;    // Owner when no_port is low
  } grant_t;

  // ------------------------------
  // Arbiter FSM
  // ------------------------------
  typedef enum logic [1:0]
  {
    ARB_OPEN,    // Free to re-arbitrate
    ARB_BURST,   // Inside a fixed-length burst
    ARB_LOCKED   // Locked sequence in progress
  } arb_state_e;

endpackage

`default_nettype wire

// ==== rtl/ahb_out_arb.sv ====
// Burst arbiter of the output stage, instantiated by ahb_out_stage to pick the slave owner
`timescale 1ns/1ns
`default_nettype none

`include "ahb_mtx_defines.svh"

module ahb_out_arb
(
  input  logic                   i_hclk,
  input  logic                   HRESETn,
  input  ahb_mtx_pkg::ahb_ctrl_t i_port_ctrl [`AHB_NUM_PORTS], // Per-port address phase
  input  logic [`AHB_NUM_PORTS-1:0] i_held_tran,              // Input stage holds a transfer
  input  ahb_mtx_pkg::ahb_ctrl_t i_slave_ctrl,                // Currently routed control
  input  logic                   i_hreadymux,                 // Phase completes this edge
  output ahb_mtx_pkg::grant_t    o_grant
);

  logic [`AHB_NUM_PORTS-1:0] req;         // Qualified requests
  logic                      pick_none;   // No request at all
  ahb_mtx_pkg::port_idx_t    pick_port;   // Lowest requesting port
  logic                      hsel_lock;   // Lock seen while selected
  logic                      hsel_lock_nxt;
  logic                      hlock_arb;   // Mastlock as the arbiter trusts it
  ahb_mtx_pkg::beat_t        beat_cnt;
  ahb_mtx_pkg::beat_t        beat_nxt;
  ahb_mtx_pkg::arb_state_e   arb_state;
  ahb_mtx_pkg::arb_state_e   state_nxt;
  ahb_mtx_pkg::grant_t       grant_q;
  ahb_mtx_pkg::grant_t       grant_nxt;
  logic                      hold;        // Keep current owner

  // Beats after the first one for each HBURST code
  function automatic ahb_mtx_pkg::beat_t burst_beats(input ahb_mtx_pkg::burst_t burst);
    ahb_mtx_pkg::beat_t beats;
    case (burst)
      `AHB_BURST_SINGLE, `AHB_BURST_INCR:  beats = ahb_mtx_pkg::beat_t'(0);  // No fixed length
      `AHB_BURST_WRAP4,  `AHB_BURST_INCR4:  beats = ahb_mtx_pkg::beat_t'(3);
      `AHB_BURST_WRAP8,  `AHB_BURST_INCR8:  beats = ahb_mtx_pkg::beat_t'(7);
      `AHB_BURST_WRAP16, `AHB_BURST_INCR16: beats = ahb_mtx_pkg::beat_t'(15);
    endcase
    return beats;
  endfunction

  // ------------------------------
  // Request qualification
  // ------------------------------
  always_comb
  begin
    for (int i = 0; i < `AHB_NUM_PORTS; i++)
    begin
      req[i] = i_port_ctrl[i].sel & i_held_tran[i];
    end
  end

  // Fixed priority, walk down so the lowest index is assigned last
  always_comb
  begin
    pick_none = 1'b1;
    pick_port = '0;
    for (int i = `AHB_NUM_PORTS - 1; i >= 0; i--)
    begin
      if (req[i])
      begin
        pick_none = 1'b0;
        pick_port = ahb_mtx_pkg::port_idx_t'(i);
      end
    end
  end

  // ------------------------------
  // Lock tracking
  // ------------------------------
  // Master may drop HSEL mid-lock to talk to another region
  assign hsel_lock_nxt = (i_slave_ctrl.sel & i_slave_ctrl.trans[1] & i_slave_ctrl.mastlock) ?
                         1'b1 :
                         (!i_slave_ctrl.mastlock) ? 1'b0 : hsel_lock;

  assign hlock_arb = i_slave_ctrl.mastlock & (hsel_lock | i_slave_ctrl.sel);

  // ------------------------------
  // Beat counting and FSM
  // ------------------------------
  always_comb
  begin
    beat_nxt = beat_cnt;
    if (!i_slave_ctrl.sel)
      beat_nxt = '0;                                // Slave not addressed
    else
      case (i_slave_ctrl.trans)
        `AHB_TRANS_IDLE:   beat_nxt = '0;          // Early end of burst
        `AHB_TRANS_BUSY:   beat_nxt = beat_cnt;    // Pause, count holds
        `AHB_TRANS_NONSEQ: beat_nxt = burst_beats(i_slave_ctrl.burst);
        `AHB_TRANS_SEQ:
        begin
          // Count only inside a burst or lock
          if ((arb_state != ahb_mtx_pkg::ARB_OPEN) && (beat_cnt != '0))
            beat_nxt = beat_cnt - 1'b1;
        end
      endcase
  end

  // Lock wins over burst
  always_comb
  begin
    if (hlock_arb)
      state_nxt = ahb_mtx_pkg::ARB_LOCKED;
    else if (beat_nxt != '0)
      state_nxt = ahb_mtx_pkg::ARB_BURST;
    else
      state_nxt = ahb_mtx_pkg::ARB_OPEN;
  end

  // ------------------------------
  // Grant selection
  // ------------------------------
  assign hold = (state_nxt == ahb_mtx_pkg::ARB_LOCKED) ||
                ((state_nxt == ahb_mtx_pkg::ARB_BURST) && (beat_nxt != '0));

  always_comb
  begin
    grant_nxt = grant_q;
    if (!hold)
    begin
      grant_nxt.no_port = pick_none;
      grant_nxt.port    = pick_port;
    end
  end

  // Everything moves only on a completing edge
  always_ff @(posedge i_hclk)
  begin
    if (!HRESETn)
    begin
      grant_q.no_port <= 1'b1;
      grant_q.port    <= '0;
      arb_state       <= ahb_mtx_pkg::ARB_OPEN;
      beat_cnt        <= '0;
      hsel_lock       <= 1'b0;
    end
    else if (i_hreadymux)
    begin
      grant_q   <= grant_nxt;
      arb_state <= state_nxt;
      beat_cnt  <= beat_nxt;
      hsel_lock <= hsel_lock_nxt;
    end
  end

  assign o_grant = grant_q;

endmodule

`default_nettype wire

// ==== rtl/ahb_addr_route.sv ====
// Address phase multiplexer of the output stage, steering the granted port onto the slave
`timescale 1ns/1ns
`default_nettype none

`include "ahb_mtx_defines.svh"

module ahb_addr_route
(
  input  ahb_mtx_pkg::ahb_ctrl_t    i_port_ctrl [`AHB_NUM_PORTS], // All ports' address phase
  input  ahb_mtx_pkg::grant_t       i_grant,                      // Registered owner
  output ahb_mtx_pkg::ahb_ctrl_t    o_slave_ctrl,                 // Shared slave side
  output logic [`AHB_NUM_PORTS-1:0] o_active                      // One-hot owner flags
);

  logic [`AHB_NUM_PORTS-1:0] port_hit;   // Grant decoded per port

  // ------------------------------
  // Grant decode
  // ------------------------------
  always_comb
  begin
    port_hit = '0;
    if (!i_grant.no_port)
    begin
      for (int i = 0; i < `AHB_NUM_PORTS; i++)
      begin
        port_hit[i] = (i_grant.port == ahb_mtx_pkg::port_idx_t'(i));
      end
    end
  end

  assign o_active = port_hit;   // Back to the input stages

  // ------------------------------
  // Control multiplexer
  // ------------------------------
  // Idle bus with sel low when nobody owns the slave
  always_comb
  begin
    o_slave_ctrl       = '0;
    o_slave_ctrl.trans = `AHB_TRANS_IDLE;
    for (int i = 0; i < `AHB_NUM_PORTS; i++)
    begin
      if (port_hit[i])
        o_slave_ctrl = i_port_ctrl[i];   // Whole bundle incl. sel
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ahb_data_phase.sv ====
// Data phase half of the output stage that muxes HWDATA and builds HREADYMUXM for the slave
`timescale 1ns/1ns
`default_nettype none

`include "ahb_mtx_defines.svh"

module ahb_data_phase
(
  input  logic                i_hclk,
  input  logic                HRESETn,
  input  ahb_mtx_pkg::data_t  i_port_wdata [`AHB_NUM_PORTS], // Write data from each port
  input  ahb_mtx_pkg::grant_t i_grant,                       // Address phase owner
  input  logic                i_slave_sel,                   // Routed HSEL
  input  logic                i_hreadyout,                   // Slave HREADYOUT
  output ahb_mtx_pkg::data_t  o_hwdata,                      // HWDATAM
  output logic                o_hreadymux                    // HREADYMUXM
);

  ahb_mtx_pkg::grant_t data_grant;   // Owner of the data phase
  logic                slave_sel;    // Slave addressed last phase

  // ------------------------------
  // Data phase registers
  // ------------------------------
  // Address phase owner becomes data phase owner
  always_ff @(posedge i_hclk)
  begin
    if (!HRESETn)
    begin
      data_grant.no_port <= 1'b1;
      data_grant.port    <= '0;
    end
    else if (o_hreadymux)
    begin
      data_grant <= i_grant;
    end
  end

  always_ff @(posedge i_hclk)
  begin
    if (!HRESETn)
      slave_sel <= 1'b0;
    else if (o_hreadymux)
      slave_sel <= i_slave_sel;   // Same edge as data_grant
  end

  // ------------------------------
  // Write data mux
  // ------------------------------
  always_comb
  begin
    o_hwdata = '0;   // Zero when no owner
    if (!data_grant.no_port)
    begin
      for (int i = 0; i < `AHB_NUM_PORTS; i++)
      begin
        if (data_grant.port == ahb_mtx_pkg::port_idx_t'(i))
          o_hwdata = i_port_wdata[i];
      end
    end
  end

  // ------------------------------
  // HREADYMUXM
  // ------------------------------
  // Slave only stalls a phase it was part of
  assign o_hreadymux = slave_sel ? i_hreadyout : 1'b1;

endmodule

`default_nettype wire

// ==== rtl/ahb_out_stage.sv ====
// Top of the bus matrix output stage, routing one of the input ports onto the shared AHB slave
`timescale 1ns/1ns
`default_nettype none

`include "ahb_mtx_defines.svh"

module ahb_out_stage
(
  input  logic                      i_hclk,       // HCLK
  input  logic                      HRESETn,      // Sync, active low
  input  ahb_mtx_pkg::ahb_ctrl_t    i_port_ctrl [`AHB_NUM_PORTS], // Port address phase
  input  ahb_mtx_pkg::data_t        i_port_wdata [`AHB_NUM_PORTS], // Port write data
  input  logic [`AHB_NUM_PORTS-1:0] i_held_tran,  // Input stage has a held transfer
  input  logic                      i_hreadyout,  // HREADYOUTM from slave
  output logic [`AHB_NUM_PORTS-1:0] o_active,     // Port owns the slave
  output ahb_mtx_pkg::ahb_ctrl_t    o_slave_ctrl, // Slave address phase
  output ahb_mtx_pkg::data_t        o_hwdata,     // HWDATAM
  output logic                      o_hreadymux   // HREADYMUXM
);

  ahb_mtx_pkg::grant_t grant;   // Registered owner

  // ------------------------------
  // Request decode and arbitration
  // ------------------------------
  // Watches the routed control for bursts and locks
  ahb_out_arb u_arb
  (
    .i_hclk       (i_hclk),
    .HRESETn      (HRESETn),
    .i_port_ctrl  (i_port_ctrl),
    .i_held_tran  (i_held_tran),
    .i_slave_ctrl (o_slave_ctrl),
    .i_hreadymux  (o_hreadymux),
    .o_grant      (grant)
  );

  // ------------------------------
  // Address phase routing
  // ------------------------------
  ahb_addr_route u_addr_route
  (
    .i_port_ctrl  (i_port_ctrl),
    .i_grant      (grant),
    .o_slave_ctrl (o_slave_ctrl),
    .o_active     (o_active)
  );

  // ------------------------------
  // Data phase completion
  // ------------------------------
  ahb_data_phase u_data_phase
  (
    .i_hclk       (i_hclk),
    .HRESETn      (HRESETn),
    .i_port_wdata (i_port_wdata),
    .i_grant      (grant),
    .i_slave_sel  (o_slave_ctrl.sel),  // Routed HSEL
    .i_hreadyout  (i_hreadyout),
    .o_hwdata     (o_hwdata),
    .o_hreadymux  (o_hreadymux)       // Also feeds the arbiter
  );

endmodule

`default_nettype wire

// ==== tests/tb_ahb_out_stage.sv ====
// Self-checking testbench for ahb_out_stage, run as the simulation top with compile.f
`timescale 1ns/1ns
`default_nettype none

`include "ahb_mtx_defines.svh"

module tb_ahb_out_stage;

  localparam int CLK_HALF    = 50;
  localparam int DRIVE_DLY   = 10;   // Inputs change after the edge
  localparam int PHASE_LIMIT = 50;   // Cycles a phase may stall
  localparam int TEST_CYCLES = 4 + 8 + 10 + 14 + 14 + 120;
  localparam int WATCHDOG_NS = (TEST_CYCLES + 16) * 2 * CLK_HALF * 3 / 2;

  logic                            hclk;
  logic                            HRESETn;
  ahb_mtx_pkg::ahb_ctrl_t          port_ctrl [`AHB_NUM_PORTS];
  ahb_mtx_pkg::data_t              port_wdata [`AHB_NUM_PORTS];
  logic [`AHB_NUM_PORTS-1:0]       held_tran;
  logic                            hreadyout;
  logic [`AHB_NUM_PORTS-1:0]       active;
  ahb_mtx_pkg::ahb_ctrl_t          slave_ctrl;
  ahb_mtx_pkg::data_t              hwdata;
  logic                            hreadymux;

  logic [15:0] lfsr_q;        // Stimulus LFSR
  logic        rand_ready;    // Random HREADYOUTM
  int          err_count;
  int          err_mark;      // Errors before current test
  int          test_num;
  int          failed_tests;

  // Reference model state
  int                              m_owner;     // -1 when nobody owns
  int                              m_dport;     // Data phase owner
  logic                            m_dsel;      // Slave addressed last phase
  logic                            m_lock_hold;
  int                              m_beats;
  ahb_mtx_pkg::ahb_ctrl_t          exp_ctrl;
  logic [`AHB_NUM_PORTS-1:0]       exp_active;
  ahb_mtx_pkg::data_t              exp_hwdata;
  logic                            exp_ready;

  ahb_out_stage uut
  (
    .i_hclk       (hclk),
    .HRESETn      (HRESETn),
    .i_port_ctrl  (port_ctrl),
    .i_port_wdata (port_wdata),
    .i_held_tran  (held_tran),
    .i_hreadyout  (hreadyout),
    .o_active     (active),
    .o_slave_ctrl (slave_ctrl),
    .o_hwdata     (hwdata),
    .o_hreadymux  (hreadymux)
  );

  initial
  begin
    hclk = 1'b0;
    forever #(CLK_HALF) hclk = ~hclk;
  end

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};   // One step per bit
    end
  endtask

  task automatic new_wdata(input int p);
    logic [31:0] d;
    rand_bits(32, d);
    port_wdata[p] = d;
  endtask

  task automatic request_single(input int p, input logic lock);
    logic [31:0] a;
    rand_bits(32, a);
    port_ctrl[p] = '{sel: 1'b1, addr: a, trans: `AHB_TRANS_NONSEQ, write: 1'b1, size: 3'b010,
                     burst: `AHB_BURST_SINGLE, prot: 4'h3, master: 4'(p), mastlock: lock};
    held_tran[p] = 1'b1;
    new_wdata(p);
  endtask

  task automatic idle_port(input int p);
    port_ctrl[p] = '0;   // Sel low and IDLE
    held_tran[p] = 1'b0;
  endtask

  // Wait for a completing edge with HREADYOUTM random when enabled
  task automatic step_phase();
    logic [31:0] r;
    logic        rdy;
    int          waits;
    rdy   = 1'b0;
    waits = 0;
    while (!rdy && waits < PHASE_LIMIT)
    begin
      if (rand_ready)
      begin
        rand_bits(1, r);
        hreadyout = r[0];
      end
      #1;
      rdy = hreadymux;   // Settled before the edge
      @(posedge hclk);
      #(DRIVE_DLY);
      waits++;
    end
    if (!rdy)
    begin
      err_count++;
      $display("Phase did not complete within %0d cycles", PHASE_LIMIT);
    end
  endtask

  // Grant then nbeats address phases and the last data phase
  task automatic run_burst(input int p, input ahb_mtx_pkg::burst_t burst, input int nbeats);
    request_single(p, 1'b0);
    port_ctrl[p].burst = burst;
    step_phase();
    held_tran[p] = 1'b0;   // Transfer now passes through
    for (int b = 0; b < nbeats; b++)
    begin
      step_phase();
      new_wdata(p);        // Data of beat b
      if (b < nbeats - 1)
      begin
        port_ctrl[p].trans = `AHB_TRANS_SEQ;
        port_ctrl[p].addr  = port_ctrl[p].addr + 32'd4;
      end
      else
        idle_port(p);
    end
    step_phase();
  endtask

  task automatic finish_test(input string name);
    test_num++;
    if (err_count != err_mark)
      failed_tests++;
    $display("Test %0d %s: %s (%0d errors)", test_num, name,
             (err_count == err_mark) ? "pass" : "fail", err_count - err_mark);
    err_mark = err_count;
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic int burst_len(input ahb_mtx_pkg::burst_t b);
    case (b)
      `AHB_BURST_WRAP4, `AHB_BURST_INCR4:   return 4;
      `AHB_BURST_WRAP8, `AHB_BURST_INCR8:   return 8;
      `AHB_BURST_WRAP16, `AHB_BURST_INCR16: return 16;
      default:                              return 1;   // SINGLE and INCR
    endcase
  endfunction

  function automatic int lowest_requester();
    for (int i = 0; i < `AHB_NUM_PORTS; i++)
    begin
      if (port_ctrl[i].sel && held_tran[i])
        return i;
    end
    return -1;
  endfunction

  always_comb
  begin
    exp_ctrl   = '0;
    exp_active = '0;
    if (m_owner >= 0)
    begin
      exp_ctrl            = port_ctrl[m_owner];
      exp_active[m_owner] = 1'b1;
    end
    exp_hwdata = (m_dport >= 0) ? port_wdata[m_dport] : '0;
    exp_ready  = m_dsel ? hreadyout : 1'b1;
  end

  always @(posedge hclk)
  begin : ref_model
    int   beats_n;
    logic lock_ok;
    if (!HRESETn)
    begin
      m_owner     <= -1;
      m_dport     <= -1;
      m_dsel      <= 1'b0;
      m_lock_hold <= 1'b0;
      m_beats     <= 0;
    end
    else if (exp_ready)
    begin
      lock_ok = exp_ctrl.mastlock && (exp_ctrl.sel || m_lock_hold);
      if (!exp_ctrl.sel || exp_ctrl.trans == `AHB_TRANS_IDLE)
        beats_n = 0;
      else if (exp_ctrl.trans == `AHB_TRANS_NONSEQ)
        beats_n = burst_len(exp_ctrl.burst) - 1;
      else if (exp_ctrl.trans == `AHB_TRANS_SEQ && m_beats > 0)
        beats_n = m_beats - 1;
      else
        beats_n = m_beats;   // BUSY pauses
      if (exp_ctrl.sel && exp_ctrl.trans[1] && exp_ctrl.mastlock)
        m_lock_hold <= 1'b1;
      else if (!exp_ctrl.mastlock)
        m_lock_hold <= 1'b0;
      if (!lock_ok && beats_n == 0)
        m_owner <= lowest_requester();   // Free to re-arbitrate
      m_beats <= beats_n;
      m_dport <= m_owner;
      m_dsel  <= exp_ctrl.sel;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  task automatic log_mismatch(input string name, input logic [63:0] exp, input logic [63:0] got);
    err_count++;
    $display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, got);
  endtask

  a_active: assert property (@(posedge hclk) disable iff (!HRESETn) active == exp_active)
    else log_mismatch("o_active", $sampled(exp_active), $sampled(active));
  a_ctrl: assert property (@(posedge hclk) disable iff (!HRESETn) slave_ctrl == exp_ctrl)
    else log_mismatch("o_slave_ctrl", $sampled(exp_ctrl), $sampled(slave_ctrl));
  a_hwdata: assert property (@(posedge hclk) disable iff (!HRESETn) hwdata == exp_hwdata)
    else log_mismatch("o_hwdata", $sampled(exp_hwdata), $sampled(hwdata));
  a_ready: assert property (@(posedge hclk) disable iff (!HRESETn) hreadymux == exp_ready)
    else log_mismatch("o_hreadymux", $sampled(exp_ready), $sampled(hreadymux));
  // Routed outputs frozen across a wait state
  a_hold_ctrl: assert property (@(posedge hclk) disable iff (!HRESETn)
    $past(hreadymux) || slave_ctrl == $past(slave_ctrl))
    else log_mismatch("o_slave_ctrl during wait", $past(slave_ctrl), $sampled(slave_ctrl));
  a_hold_active: assert property (@(posedge hclk) disable iff (!HRESETn)
    $past(hreadymux) || active == $past(active))
    else log_mismatch("o_active during wait", $past(active), $sampled(active));
  a_hold_hwdata: assert property (@(posedge hclk) disable iff (!HRESETn)
    $past(hreadymux) || hwdata == $past(hwdata))
    else log_mismatch("o_hwdata during wait", $past(hwdata), $sampled(hwdata));

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial
  begin
    lfsr_q       = 16'd64;
    rand_ready   = 1'b0;
    err_count    = 0;
    err_mark     = 0;
    test_num     = 0;
    failed_tests = 0;
    HRESETn      = 1'b0;
    hreadyout    = 1'b1;
    for (int p = 0; p < `AHB_NUM_PORTS; p++)
    begin
      idle_port(p);
      port_wdata[p] = '0;
    end
    repeat (16) @(posedge hclk);
    #(DRIVE_DLY);
    HRESETn = 1'b1;

    step_phase();   // Reset values with nobody requesting
    step_phase();
    finish_test("reset");

    run_burst(1, `AHB_BURST_SINGLE, 1);
    finish_test("single request");

    for (int p = 0; p < `AHB_NUM_PORTS; p++)
      request_single(p, 1'b0);
    step_phase();   // Port 0 first
    for (int p = 0; p < `AHB_NUM_PORTS; p++)
    begin
      held_tran[p] = 1'b0;
      if (p > 0)
        idle_port(p - 1);
      step_phase();
    end
    idle_port(2);
    step_phase();
    finish_test("priority");

    // Port 0 asks while port 1 owns an INCR4
    request_single(1, 1'b0);
    port_ctrl[1].burst = `AHB_BURST_INCR4;
    step_phase();
    held_tran[1] = 1'b0;
    request_single(0, 1'b0);
    for (int b = 0; b < 4; b++)
    begin
      step_phase();
      new_wdata(1);
      port_ctrl[1].trans = `AHB_TRANS_SEQ;
      port_ctrl[1].addr  = port_ctrl[1].addr + 32'd4;
    end
    idle_port(1);
    held_tran[0] = 1'b0;
    step_phase();
    idle_port(0);
    step_phase();
    finish_test("burst hold");

    request_single(2, 1'b1);
    step_phase();
    held_tran[2] = 1'b0;
    request_single(0, 1'b0);
    step_phase();              // Lock hold set
    port_ctrl[2].sel = 1'b0;   // Off to another slave
    step_phase();
    step_phase();
    port_ctrl[2].sel = 1'b1;
    step_phase();
    port_ctrl[2].mastlock = 1'b0;
    port_ctrl[2].trans    = `AHB_TRANS_IDLE;
    step_phase();              // Port 0 takes over
    idle_port(2);
    held_tran[0] = 1'b0;
    step_phase();
    idle_port(0);
    step_phase();
    finish_test("lock");

    rand_ready = 1'b1;
    run_burst(0, `AHB_BURST_SINGLE, 1);
    run_burst(1, `AHB_BURST_INCR4, 4);
    run_burst(2, `AHB_BURST_SINGLE, 1);
    rand_ready = 1'b0;
    hreadyout  = 1'b1;
    step_phase();
    finish_test("wait states");

    $display("Tests: %0d  failed: %0d  errors: %0d", test_num, failed_tests, err_count);
    if (err_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  // Hung handshake guard
  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
rtl/ahb_mtx_pkg.sv
rtl/ahb_out_arb.sv
rtl/ahb_addr_route.sv
rtl/ahb_data_phase.sv
rtl/ahb_out_stage.sv
tests/tb_ahb_out_stage.sv

// ==== Bender.yml ====
package:
  name: ahb_out_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/ahb_mtx_pkg.sv
      - rtl/ahb_out_arb.sv
      - rtl/ahb_addr_route.sv
      - rtl/ahb_data_phase.sv
      - rtl/ahb_out_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_ahb_out_stage.sv
